/* Makefile */
# Verilator build and run for the Huffman encoder testbench.

VERILATOR ?= verilator
TOP       ?= huffman_encoder_tb
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_TEXT ?= TB PASSED

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

/* tests/huffman_encoder_assertions.sv */
`timescale 1ns/1ps

module huffman_encoder_assertions (
   input logic               clk,
   input logic               rst,
   input huffman_pkg::fill_t fill,
   input logic               take,
   input logic               take_all,
   input logic               last
);

   // ####################
   // staging bounds
   // ####################

   fill_in_range : assert property (@(posedge clk) disable iff (rst)
      fill <= huffman_pkg::fill_t'(huffman_pkg::ACC_W))
      else $error("accumulator fill above capacity");

   take_exclusive : assert property (@(posedge clk) disable iff (rst)
      !(take && take_all))
      else $error("take and take_all high together");

   // a word may only leave once it is complete.
   take_needs_word : assert property (@(posedge clk) disable iff (rst)
      take |-> fill >= huffman_pkg::fill_t'(huffman_pkg::WORD_W))
      else $error("take while fewer than 16 bits held");

   // ####################
   // pulse shape
   // ####################

   last_one_cycle : assert property (@(posedge clk) disable iff (rst)
      last |=> !last)
      else $error("last held for more than one cycle");

endmodule

bind word_emitter huffman_encoder_assertions i_huffman_encoder_assertions (
   .clk      (clk),
   .rst      (rst),
   .fill     (fifo.fill),
   .take     (fifo.take),
   .take_all (fifo.take_all),
   .last     (last)
);

/* tests/huffman_encoder_tb.sv */
`timescale 1ns/1ps

module huffman_encoder_tb;

   localparam int CLK_PERIOD  = 4;
   localparam int RAND_COUNT  = 200;
   localparam int FLUSH_WAIT  = 40;   // cycles allowed from flush to last.
   localparam int STIM_CYCLES = 10 + 16 + 24 + 8 + 1 + 2 * RAND_COUNT + 36 + 6 * (FLUSH_WAIT + 4);
   localparam int WATCHDOG_CYCLES = 2 * STIM_CYCLES + 200;

   logic                 clk;
   logic                 rst;
   logic                 enable;
   logic                 flush;
   huffman_pkg::symbol_t data_in;
   huffman_pkg::word_t   data_out;
   logic                 word_valid;
   logic                 last;

   int cycle = 0;  // number of rising edges so far.

   // captured by the monitor.
   huffman_pkg::word_t got_words [$];
   logic               got_last [$];
   int                 got_cycle [$];
   int                 last_count = 0;
   int                 lone_last_count = 0;

   // reference model state.
   logic               model_bits [$];
   huffman_pkg::word_t exp_words [$];
   logic               exp_last [$];
   int                 exp_cycle [$];  // -1 where no latency is promised.
   logic               exp_lone_last;

   int     word_base;
   int     lone_base;
   int     last_base;
   int     checks;
   int     errors;
   int     tests_run;
   int     tests_failed;
   int     test_err_base;
   string  test_name;
   integer seed;

   huffman_encoder i_huffman_encoder (
      .clk        (clk),
      .rst        (rst),
      .enable     (enable),
      .data_in    (data_in),
      .flush      (flush),
      .data_out   (data_out),
      .word_valid (word_valid),
      .last       (last)
   );

   always #(CLK_PERIOD / 2) clk = ~clk;

   always @(posedge clk) cycle <= cycle + 1;

   // outputs settle after the rising edge, so look at them on the falling one.
   always @(negedge clk) begin
      if (!rst) begin
         if (word_valid) begin
            got_words.push_back(data_out);
            got_last.push_back(last);
            got_cycle.push_back(cycle);
         end else if (last) begin
            lone_last_count++;
         end
         if (last) last_count++;
      end
   end

   initial begin
      #(WATCHDOG_CYCLES * CLK_PERIOD);
      $display("watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
      $display("TB FAILED");
      $finish;
   end

   // ####################
   // compare tasks
   // ####################

   task automatic compare_word(input huffman_pkg::word_t got, input huffman_pkg::word_t exp,
                               input string what);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("Fail %0t: %s got %h expected %h", $time, what, got, exp);
      end
   endtask

   task automatic compare_last(input logic got, input logic exp, input string what);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("Fail %0t: %s got %b expected %b", $time, what, got, exp);
      end
   endtask

   task automatic compare_cycle(input int got, input int exp, input string what);
      checks++;
      if (got != exp) begin
         errors++;
         $display("Fail %0t: %s at edge %0d expected edge %0d", $time, what, got, exp);
      end
   endtask

   // ####################
   // reference model
   // ####################

   task automatic model_word(input logic is_last, input int due);
      huffman_pkg::word_t w;
      w = '0;
      for (int i = 0; i < huffman_pkg::WORD_W; i++) begin
         if (model_bits.size() > 0) w = {w[huffman_pkg::WORD_W-2:0], model_bits.pop_front()};
         else w = {w[huffman_pkg::WORD_W-2:0], 1'b0};  // zero padding.
      end
      exp_words.push_back(w);
      exp_last.push_back(is_last);
      exp_cycle.push_back(due);
   endtask

   // k zeros, then sym+1 in k+1 digits.
   task automatic model_symbol(input huffman_pkg::symbol_t sym, input int edge_no);
      int n;
      int k;
      n = int'(sym) + 1;
      k = 0;
      while ((n >> (k + 1)) != 0) k++;
      repeat (k) model_bits.push_back(1'b0);
      for (int i = k; i >= 0; i--) model_bits.push_back(n[i]);
      while (model_bits.size() >= huffman_pkg::WORD_W) model_word(1'b0, edge_no + 2);
   endtask

   task automatic model_flush();
      if (model_bits.size() > 0) model_word(1'b1, -1);
      else exp_lone_last = 1'b1;
   endtask

   // ####################
   // stimulus
   // ####################

   task automatic clear_model();
      model_bits.delete();
      exp_words.delete();
      exp_last.delete();
      exp_cycle.delete();
      exp_lone_last = 1'b0;
      word_base = got_words.size();
      lone_base = lone_last_count;
      last_base = last_count;
   endtask

   task automatic start_test(input string name);
      test_name     = name;
      test_err_base = errors;
      clear_model();
   endtask

   task automatic send_symbol(input huffman_pkg::symbol_t sym);
      @(negedge clk);
      enable  = 1'b1;
      flush   = 1'b0;
      data_in = sym;
      model_symbol(sym, cycle + 1);  // sampled at the coming edge.
   endtask

   task automatic send_idle();
      @(negedge clk);
      enable = 1'b0;
      flush  = 1'b0;
   endtask

   task automatic flush_and_wait();
      int waited;
      @(negedge clk);
      enable = 1'b0;
      flush  = 1'b1;
      model_flush();
      @(negedge clk);
      flush  = 1'b0;
      waited = 0;
      while (last_count == last_base && waited < FLUSH_WAIT) begin
         @(posedge clk);
         waited++;
      end
      if (last_count == last_base) begin
         errors++;
         $display("%s: no last pulse within %0d cycles after flush", test_name, FLUSH_WAIT);
      end
      repeat (3) @(posedge clk);  // room for any stray word.
   endtask

   task automatic check_results(input logic with_latency);
      int n;
      n = got_words.size() - word_base;
      if (n != exp_words.size()) begin
         errors++;
         $display("%s: expected %0d words but the DUT sent %0d", test_name, exp_words.size(), n);
      end
      for (int i = 0; i < n && i < exp_words.size(); i++) begin
         compare_word(got_words[word_base + i], exp_words[i], $sformatf("word %0d", i));
         compare_last(got_last[word_base + i], exp_last[i], $sformatf("last with word %0d", i));
         if (with_latency && exp_cycle[i] >= 0) begin
            compare_cycle(got_cycle[word_base + i], exp_cycle[i], $sformatf("word %0d", i));
         end
      end
      compare_last(logic'(lone_last_count != lone_base), exp_lone_last, "last without a word");
   endtask

   task automatic end_test();
      tests_run++;
      if (errors != test_err_base) begin
         tests_failed++;
         $display("test %s: %0d errors", test_name, errors - test_err_base);
      end else begin
         $display("test %s: ok", test_name);
      end
   endtask

   // ####################
   // directed tests
   // ####################

   task automatic test_all_ones();
      start_test("sixteen ones");
      repeat (16) send_symbol(8'd0);
      flush_and_wait();
      check_results(1'b1);
      end_test();
   endtask

   task automatic test_mixed_lengths();
      huffman_pkg::symbol_t seq [24];
      seq = '{8'd0, 8'd1, 8'd3, 8'd7, 8'd15, 8'd31, 8'd63, 8'd127, 8'd2, 8'd5, 8'd200,
              8'd100, 8'd0, 8'd0, 8'd9, 8'd254, 8'd44, 8'd6, 8'd1, 8'd130, 8'd20, 8'd0,
              8'd77, 8'd4};
      start_test("mixed lengths");
      foreach (seq[i]) send_symbol(seq[i]);
      flush_and_wait();
      check_results(1'b1);
      end_test();
   endtask

   task automatic test_long_codes();
      start_test("eight 17-bit codes");
      repeat (8) send_symbol(8'd255);  // 136 bits.
      flush_and_wait();
      check_results(1'b0);
      end_test();
   endtask

   task automatic test_partial_flush();
      start_test("partial word flush");
      send_symbol(8'd3);  // "00100".
      flush_and_wait();
      check_results(1'b0);
      end_test();
   endtask

   task automatic test_random();
      huffman_pkg::symbol_t sym;
      int                   run;
      start_test("random symbols");
      run = 0;
      for (int i = 0; i < RAND_COUNT; i++) begin
         sym = huffman_pkg::symbol_t'($random(seed));
         if (sym == 8'd255 && run == 8) begin
            send_idle();  // keep within the run limit.
            run = 0;
         end
         send_symbol(sym);
         run = (sym == 8'd255) ? run + 1 : 0;
         if (($random(seed) & 7) < 2) begin
            send_idle();
            run = 0;
         end
      end
      flush_and_wait();
      check_results(1'b0);
      end_test();
   endtask

   task automatic test_mid_reset();
      start_test("reset mid-stream");
      for (int i = 0; i < 11; i++) send_symbol(huffman_pkg::symbol_t'(i * 23 + 5));
      @(negedge clk);
      enable = 1'b0;
      rst    = 1'b1;
      @(negedge clk);
      compare_word(data_out, '0, "data_out in reset");
      compare_last(word_valid, 1'b0, "word_valid in reset");
      compare_last(last, 1'b0, "last in reset");
      repeat (2) @(negedge clk);
      rst = 1'b0;
      @(posedge clk);
      clear_model();  // no stale bits may follow.
      for (int i = 0; i < 12; i++) send_symbol(huffman_pkg::symbol_t'(i * 37 + 1));
      flush_and_wait();
      check_results(1'b1);
      end_test();
   endtask

   initial begin
      clk          = 1'b0;
      rst          = 1'b1;
      enable       = 1'b0;
      flush        = 1'b0;
      data_in      = '0;
      seed         = 8759;
      checks       = 0;
      errors       = 0;
      tests_run    = 0;
      tests_failed = 0;
      repeat (10) @(negedge clk);
      rst = 1'b0;
      test_all_ones();
      test_mixed_lengths();
      test_long_codes();
      test_partial_flush();
      test_random();
      test_mid_reset();
      $display("tests %0d, failed %0d, checks %0d, errors %0d",
               tests_run, tests_failed, checks, errors);
      if (errors == 0) begin
         $display("TB PASSED");
      end else begin
         $display("TB FAILED");
      end
      $finish;
   end

endmodule

/* verilog.f */
verilog/huffman_pkg.sv
verilog/bit_fifo_if.sv
verilog/code_lookup.sv
verilog/bit_accumulator.sv
verilog/word_emitter.sv
verilog/huffman_encoder.sv
tests/huffman_encoder_assertions.sv
tests/huffman_encoder_tb.sv

/* verilog/bit_accumulator.sv */
`timescale 1ns/1ps

module bit_accumulator (
   input  logic                   clk,
   input  logic                   rst,
   input  logic                   code_valid,
   input  huffman_pkg::code_t     code,
   input  huffman_pkg::code_len_t code_len,
   bit_fifo_if.acc                fifo
);

   localparam int PAD_W = huffman_pkg::ACC_W - huffman_pkg::CODE_W;

   logic [huffman_pkg::ACC_W-1:0] acc;       // left aligned, oldest bit at the top.
   huffman_pkg::fill_t            fill;
   logic [huffman_pkg::ACC_W-1:0] base_acc;
   huffman_pkg::fill_t            base_fill;
   logic [huffman_pkg::ACC_W-1:0] code_ext;
   huffman_pkg::code_len_t        shift_up;
   logic [huffman_pkg::ACC_W-1:0] acc_next;
   huffman_pkg::fill_t            fill_next;

   assign fifo.head_word = acc[huffman_pkg::ACC_W-1 -: huffman_pkg::WORD_W];
   assign fifo.fill      = fill;

   // ####################
   // remove, then append
   // ####################

   always_comb begin
      if (fifo.take) begin
         base_acc  = acc << huffman_pkg::WORD_W;
         base_fill = fill - huffman_pkg::fill_t'(huffman_pkg::WORD_W);
      end else if (fifo.take_all) begin
         base_acc  = '0;
         base_fill = '0;
      end else begin
         base_acc  = acc;
         base_fill = fill;
      end
   end

   // move the code to the top of a 48-bit word.
   // the unused high bits of the code fall off the left end.
   assign shift_up = huffman_pkg::code_len_t'(huffman_pkg::CODE_W) - code_len;
   assign code_ext = {code, {PAD_W{1'b0}}} << shift_up;

   always_comb begin
      if (code_valid) begin
         acc_next  = base_acc | (code_ext >> base_fill);  // lands just below the kept bits.
         fill_next = base_fill + huffman_pkg::fill_t'(code_len);
      end else begin
         acc_next  = base_acc;
         fill_next = base_fill;
      end
   end

   // ####################
   // state
   // ####################

   // bits below the fill stay zero, so or-ing in a new code is enough.
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         acc  <= '0;
         fill <= '0;
      end else begin
         acc  <= acc_next;
         fill <= fill_next;
      end
   end

endmodule

/* verilog/bit_fifo_if.sv */
`timescale 1ns/1ps

// link between the bit staging register and the word emitter.
interface bit_fifo_if;
   huffman_pkg::word_t head_word;  // oldest 16 bits, msb first.
   huffman_pkg::fill_t fill;       // valid bits held.
   logic               take;       // drop one word at the edge.
   logic               take_all;   // drop everything at the edge.

   modport acc (
      output head_word,
      output fill,
      input  take,
      input  take_all
   );

   modport emit (
      input  head_word,
      input  fill,
      output take,
      output take_all
   );

endinterface

/* verilog/code_lookup.sv */
`timescale 1ns/1ps

module code_lookup (
   input  logic                   clk,
   input  logic                   rst,
   input  logic                   enable,
   input  huffman_pkg::symbol_t   data_in,
   output logic                   code_valid,
   output huffman_pkg::code_t     code,
   output huffman_pkg::code_len_t code_len
);

   // ####################
   // rom
   // ####################

   huffman_pkg::code_t     code_rom [2**huffman_pkg::SYMBOL_W];
   huffman_pkg::code_len_t len_rom  [2**huffman_pkg::SYMBOL_W];

   // one entry per symbol, constant after elaboration.
   for (genvar i = 0; i < 2**huffman_pkg::SYMBOL_W; i++) begin : g_rom
      assign code_rom[i] = huffman_pkg::code_of(huffman_pkg::symbol_t'(i));
      assign len_rom[i]  = huffman_pkg::code_len_of(huffman_pkg::symbol_t'(i));
   end

   // ####################
   // output stage
   // ####################

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         code_valid <= 1'b0;
      end else begin
         code_valid <= enable;  // one pulse per sampled symbol.
      end
   end

   // entry only changes when a new symbol comes in.
   always_ff @(posedge clk) begin
      if (enable) begin
         code     <= code_rom[data_in];
         code_len <= len_rom[data_in];
      end
   end

endmodule

/* verilog/huffman_encoder.sv */
`timescale 1ns/1ps

module huffman_encoder (
   input  logic                 clk,
   input  logic                 rst,
   input  logic                 enable,
   input  huffman_pkg::symbol_t data_in,
   input  logic                 flush,
   output huffman_pkg::word_t   data_out,
   output logic                 word_valid,
   output logic                 last
);

   logic                   code_valid;
   huffman_pkg::code_t     code;
   huffman_pkg::code_len_t code_len;

   bit_fifo_if fifo_if ();

   // symbol to code, one cycle.
   code_lookup i_code_lookup (
      .clk        (clk),
      .rst        (rst),
      .enable     (enable),
      .data_in    (data_in),
      .code_valid (code_valid),
      .code       (code),
      .code_len   (code_len)
   );

   bit_accumulator i_bit_accumulator (
      .clk        (clk),
      .rst        (rst),
      .code_valid (code_valid),
      .code       (code),
      .code_len   (code_len),
      .fifo       (fifo_if.acc)
   );

   // also sees code_valid so a flush waits for codes in flight.
   word_emitter i_word_emitter (
      .clk        (clk),
      .rst        (rst),
      .flush      (flush),
      .code_valid (code_valid),
      .fifo       (fifo_if.emit),
      .data_out   (data_out),
      .word_valid (word_valid),
      .last       (last)
   );

endmodule

/* verilog/huffman_pkg.sv */
package huffman_pkg;

   // ####################
   // widths and sizes
   // ####################

   localparam int SYMBOL_W = 8;   // input symbol.
   localparam int CODE_W   = 17;  // longest code.
   localparam int LEN_W    = 5;   // holds lengths 1 to 17.
   localparam int WORD_W   = 16;  // output word.
   localparam int ACC_W    = 48;  // three words of staging.
   localparam int FILL_W   = 6;   // counts 0 to 48.

   typedef logic [SYMBOL_W-1:0] symbol_t;
   typedef logic [CODE_W-1:0]   code_t;
   typedef logic [LEN_W-1:0]    code_len_t;
   typedef logic [WORD_W-1:0]   word_t;
   typedef logic [FILL_W-1:0]   fill_t;

   // ####################
   // code rule
   // ####################

   // order-0 exp-golomb.
   // n = symbol + 1, k = floor(log2(n)).
   // code is k zeros then n in k+1 bits, so 2k+1 bits long.

   // the leading zeros come for free once n is right-aligned.
   function automatic code_t code_of(input symbol_t sym);
      logic [SYMBOL_W:0] n;
      n = {1'b0, sym} + 1'b1;
      return code_t'(n);
   endfunction

   function automatic code_len_t code_len_of(input symbol_t sym);
      logic [SYMBOL_W:0] n;
      code_len_t         k;
      n = {1'b0, sym} + 1'b1;
      k = '0;
      // position of the highest set bit of n.
      for (int i = 0; i <= SYMBOL_W; i++) begin
         if (n[i]) begin
            k = code_len_t'(i);
         end
      end
      return (k << 1) + code_len_t'(1);
   endfunction

endpackage

/* verilog/word_emitter.sv */
`timescale 1ns/1ps

module word_emitter (
   input  logic               clk,
   input  logic               rst,
   input  logic               flush,
   input  logic               code_valid,
   bit_fifo_if.emit           fifo,
   output huffman_pkg::word_t data_out,
   output logic               word_valid,
   output logic               last
);

   logic flush_pending;  // flush seen, tail not yet sent.
   logic whole_word;
   logic partial;
   logic flush_fire;

   // ####################
   // take decisions
   // ####################

   assign whole_word = fifo.fill >= huffman_pkg::fill_t'(huffman_pkg::WORD_W);
   assign partial    = fifo.fill != '0;

   // the tail goes only once full words are out and nothing is landing.
   assign flush_fire = flush_pending && !whole_word && !code_valid;

   assign fifo.take     = whole_word;
   assign fifo.take_all = flush_fire && partial;  // empty tail sends last alone.

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         flush_pending <= 1'b0;
      end else if (flush) begin
         flush_pending <= 1'b1;  // a new request wins over a finishing one.
      end else if (flush_fire) begin
         flush_pending <= 1'b0;
      end
   end

   // ####################
   // output register
   // ####################

   // head_word is already zero below the fill, which gives the padding.
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         data_out   <= '0;
         word_valid <= 1'b0;
         last       <= 1'b0;
      end else begin
         word_valid <= fifo.take | fifo.take_all;
         last       <= flush_fire;
         if (fifo.take || fifo.take_all) begin
            data_out <= fifo.head_word;
         end
      end
   end

endmodule
